//--- design/vid_pkg.sv
/*
 * vid_pkg
 * shared types, CPU register numbers and XR addresses of the
 * raster display controller
 */
`default_nettype none

package vid_pkg;

typedef logic [15:0] word_t;        // vram or register word
typedef logic [7:0]  addr_t;        // vram word address, 256 words
typedef logic [11:0] rgb_t;         // 4:4:4 colour, red in top nibble
typedef logic [3:0]  cidx_t;        // palette index
typedef logic [4:0]  xr_addr_t;     // XR register address
typedef logic [1:0]  intr_t;        // one bit per interrupt source

// interrupt bit positions
localparam int INTR_LINE   = 0;     // raster line compare
localparam int INTR_VBLANK = 1;     // start of vertical blank

// CPU byte bus registers (16-bit, two byte accesses each)
localparam logic [3:0] REG_INT_CTRL = 4'h0;    // mask [9:8], status/clear [1:0]
localparam logic [3:0] REG_WR_ADDR  = 4'h1;    // vram write address
localparam logic [3:0] REG_WR_INCR  = 4'h2;    // address step, rd and wr
localparam logic [3:0] REG_DATA     = 4'h3;    // vram data port
localparam logic [3:0] REG_RD_ADDR  = 4'h4;    // vram read address, starts prefetch
localparam logic [3:0] REG_XR_ADDR  = 4'h5;    // XR write address
localparam logic [3:0] REG_XR_DATA  = 4'h6;    // XR data, address steps by one

// XR register space
localparam xr_addr_t XR_PALETTE_BASE = 5'h00;  // 16 palette entries
localparam xr_addr_t XR_LINE_CMP     = 5'h10;  // raster line for INTR_LINE

endpackage

`default_nettype wire

//--- design/video_timing.sv
/*
 * video_timing
 * free running horizontal and vertical counters
 * decodes active high sync, display enable and the line, frame
 * and vblank start strobes
 */
`default_nettype none
`timescale 1ns/10ps

module video_timing #(
    parameter int H_VISIBLE = 16,
    parameter int H_FRONT   = 2,
    parameter int H_SYNC    = 4,
    parameter int H_BACK    = 2,
    parameter int V_VISIBLE = 8,
    parameter int V_FRONT   = 1,
    parameter int V_SYNC    = 2,
    parameter int V_BACK    = 1
)(
    input  wire logic   clk,
    input  wire logic   reset_i,
    output logic [$clog2(H_VISIBLE+H_FRONT+H_SYNC+H_BACK)-1:0] h_count_o,
    output logic [$clog2(V_VISIBLE+V_FRONT+V_SYNC+V_BACK)-1:0] v_count_o,
    output logic        hsync_o,
    output logic        vsync_o,
    output logic        de_o,               // visible pixel
    output logic        line_start_o,       // h = 0
    output logic        frame_start_o,      // h = 0, v = 0
    output logic        vblank_start_o      // h = 0, first blank line
);

localparam int H_TOTAL      = H_VISIBLE + H_FRONT + H_SYNC + H_BACK;
localparam int V_TOTAL      = V_VISIBLE + V_FRONT + V_SYNC + V_BACK;
localparam int H_SYNC_START = H_VISIBLE + H_FRONT;
localparam int V_SYNC_START = V_VISIBLE + V_FRONT;

always_ff @(posedge clk) begin
    if (reset_i) begin
        h_count_o <= '0;
        v_count_o <= '0;
    end else if (h_count_o == H_TOTAL - 1) begin
        h_count_o <= '0;
        if (v_count_o == V_TOTAL - 1) begin
            v_count_o <= '0;                // wrap to top of frame
        end else begin
            v_count_o <= v_count_o + 1'b1;
        end
    end else begin
        h_count_o <= h_count_o + 1'b1;
    end
end

assign hsync_o = (h_count_o >= H_SYNC_START) && (h_count_o < H_SYNC_START + H_SYNC);
assign vsync_o = (v_count_o >= V_SYNC_START) && (v_count_o < V_SYNC_START + V_SYNC);
assign de_o    = (h_count_o < H_VISIBLE) && (v_count_o < V_VISIBLE);

assign line_start_o   = (h_count_o == 0);
assign frame_start_o  = line_start_o && (v_count_o == 0);
assign vblank_start_o = line_start_o && (v_count_o == V_VISIBLE);

endmodule

`default_nettype wire

//--- design/vram_arb.sv
/*
 * vram_arb
 * 256 word video RAM, one port with registered reads
 * video reads always win, a CPU request takes the next free cycle
 * and is acked with its read data once the port is free again
 */
`default_nettype none
`timescale 1ns/10ps

module vram_arb(
    input  wire logic               clk,
    input  wire logic               reset_i,
    input  wire logic               vid_rd_i,       // video fetch, top priority
    input  wire vid_pkg::addr_t     vid_addr_i,
    input  wire logic               cpu_req_i,      // held until cpu_ack_o
    input  wire logic               cpu_wr_i,
    input  wire vid_pkg::addr_t     cpu_addr_i,
    input  wire vid_pkg::word_t     cpu_wdata_i,
    output vid_pkg::word_t          vid_data_o,     // cycle after vid_rd_i
    output logic                    cpu_ack_o,
    output vid_pkg::word_t          cpu_rdata_o     // valid with cpu_ack_o
);

import vid_pkg::*;

word_t  mem [2**$bits(addr_t)];
logic   cpu_go;         // cpu owns the port this cycle
logic   ack_due;        // cpu access done, ack still owed

assign cpu_go    = cpu_req_i && !vid_rd_i && !ack_due;
assign cpu_ack_o = ack_due && !vid_rd_i;   // never share a cycle with video

always_ff @(posedge clk) begin
    if (vid_rd_i) begin
        vid_data_o <= mem[vid_addr_i];
    end else if (cpu_go) begin
        if (cpu_wr_i) begin
            mem[cpu_addr_i] <= cpu_wdata_i;
        end
        cpu_rdata_o <= mem[cpu_addr_i];     // old word on a write, unused
    end
end

always_ff @(posedge clk) begin
    if (reset_i) begin
        ack_due <= 1'b0;
    end else if (cpu_go) begin
        ack_due <= 1'b1;
    end else if (cpu_ack_o) begin
        ack_due <= 1'b0;
    end
end

// relies on the pixel fetch leaving at least three idle cycles between reads
assert property (@(posedge clk) disable iff (reset_i)
    cpu_req_i |-> ##[0:2] cpu_ack_o)
    else $error("cpu vram request not served within two cycles");

endmodule

`default_nettype wire

//--- design/bus_regs.sv
/*
 * bus_regs
 * CPU byte bus register file and access sequencer
 * builds 16-bit words from byte pairs, keeps the vram address,
 * increment, prefetch and interrupt mask registers and drives
 * vram requests until the arbiter acks them, plus the XR write strobe
 */
`default_nettype none
`timescale 1ns/10ps

module bus_regs(
    input  wire logic               clk,
    input  wire logic               reset_i,
    input  wire logic               bus_cs_n_i,     // one access per low cycle
    input  wire logic               bus_rd_nwr_i,   // 1 = read
    input  wire logic [3:0]         bus_reg_num_i,
    input  wire logic               bus_bytesel_i,  // 0 = high byte, 1 = low byte
    input  wire logic [7:0]         bus_data_i,
    input  wire logic               vram_ack_i,
    input  wire vid_pkg::word_t     vram_data_i,
    input  wire vid_pkg::intr_t     intr_status_i,
    output logic [7:0]              bus_data_o,
    output logic                    vram_req_o,     // held until ack
    output logic                    vram_wr_o,
    output vid_pkg::addr_t          vram_addr_o,
    output vid_pkg::word_t          vram_wdata_o,
    output logic                    xr_wr_o,        // single cycle strobe
    output vid_pkg::xr_addr_t       xr_addr_o,
    output vid_pkg::word_t          xr_data_o,
    output vid_pkg::intr_t          intr_mask_o,
    output vid_pkg::intr_t          intr_clear_o
);

import vid_pkg::*;

logic [7:0] hi_byte;        // high byte waiting for its low half
word_t      wr_word;        // assembled word on commit
logic       wr_commit;      // low byte write, word takes effect
logic       rd_stb;
logic       rd_next;        // low byte read of REG_DATA, step and refetch
logic       start_req;      // a vram request starts this cycle
word_t      wr_addr;
word_t      wr_incr;
word_t      rd_addr;
word_t      xr_addr;
word_t      prefetch;       // word read ahead at rd_addr
word_t      rd_word;        // readback value of the addressed register

assign wr_word   = {hi_byte, bus_data_i};
assign wr_commit = !bus_cs_n_i && !bus_rd_nwr_i && bus_bytesel_i;
assign rd_stb    = !bus_cs_n_i && bus_rd_nwr_i;
assign rd_next   = rd_stb && bus_bytesel_i && (bus_reg_num_i == REG_DATA);
assign start_req = rd_next || (wr_commit &&
                   (bus_reg_num_i == REG_DATA || bus_reg_num_i == REG_RD_ADDR));
assign xr_addr_o = xr_addr[4:0];

always_comb begin
    case (bus_reg_num_i)
        REG_INT_CTRL: rd_word = {6'b0, intr_mask_o, 6'b0, intr_status_i};
        REG_WR_ADDR:  rd_word = wr_addr;
        REG_WR_INCR:  rd_word = wr_incr;
        REG_DATA:     rd_word = prefetch;
        REG_RD_ADDR:  rd_word = rd_addr;
        REG_XR_ADDR:  rd_word = xr_addr;
        REG_XR_DATA:  rd_word = xr_data_o;     // last word written
        default:      rd_word = '0;
    endcase
end

// control state
always_ff @(posedge clk) begin
    if (reset_i) begin
        bus_data_o   <= '0;
        vram_req_o   <= 1'b0;
        xr_wr_o      <= 1'b0;
        intr_mask_o  <= '0;
        intr_clear_o <= '0;
        wr_addr      <= '0;
        wr_incr      <= '0;
        rd_addr      <= '0;
        xr_addr      <= '0;
    end else begin
        xr_wr_o      <= 1'b0;
        intr_clear_o <= '0;
        if (xr_wr_o) begin
            xr_addr <= xr_addr + 1'b1;              // step after each XR write
        end
        if (vram_ack_i) begin
            vram_req_o <= 1'b0;
            if (vram_wr_o) begin
                wr_addr <= wr_addr + wr_incr;
            end
        end
        if (rd_stb) begin
            bus_data_o <= bus_bytesel_i ? rd_word[7:0] : rd_word[15:8];
        end
        if (rd_next) begin
            rd_addr    <= rd_addr + wr_incr;
            vram_req_o <= 1'b1;                     // fetch the next word
        end
        if (wr_commit) begin
            case (bus_reg_num_i)
                REG_INT_CTRL: begin
                    intr_mask_o  <= wr_word[9:8];
                    intr_clear_o <= wr_word[1:0];   // write 1 to clear
                end
                REG_WR_ADDR:  wr_addr <= wr_word;
                REG_WR_INCR:  wr_incr <= wr_word;
                REG_DATA:     vram_req_o <= 1'b1;
                REG_RD_ADDR: begin
                    rd_addr    <= wr_word;
                    vram_req_o <= 1'b1;
                end
                REG_XR_ADDR:  xr_addr <= wr_word;
                REG_XR_DATA:  xr_wr_o <= 1'b1;
                default: ;
            endcase
        end
    end
end

// payload, qualified by the strobes above
always_ff @(posedge clk) begin
    if (!bus_cs_n_i && !bus_rd_nwr_i && !bus_bytesel_i) begin
        hi_byte <= bus_data_i;
    end
    if (vram_ack_i && !vram_wr_o) begin
        prefetch <= vram_data_i;
    end
    if (rd_next) begin
        vram_wr_o   <= 1'b0;
        vram_addr_o <= rd_addr[7:0] + wr_incr[7:0];
    end
    if (wr_commit && bus_reg_num_i == REG_DATA) begin
        vram_wr_o    <= 1'b1;
        vram_addr_o  <= wr_addr[7:0];
        vram_wdata_o <= wr_word;
    end
    if (wr_commit && bus_reg_num_i == REG_RD_ADDR) begin
        vram_wr_o   <= 1'b0;
        vram_addr_o <= wr_word[7:0];
    end
    if (wr_commit && bus_reg_num_i == REG_XR_DATA) begin
        xr_data_o <= wr_word;
    end
end

// bus spacing must outlast the arbiter latency
assert property (@(posedge clk) disable iff (reset_i) start_req |-> !vram_req_o)
    else $error("vram request started while one is pending");

endmodule

`default_nettype wire

//--- design/pixel_pipe.sv
/*
 * pixel_pipe
 * fetches one vram word per four visible pixels, shifts its nibbles
 * out high first and looks each up in a 16 entry palette
 * sync and enable are delayed to leave with the colour, three cycles
 * after the counters
 */
`default_nettype none
`timescale 1ns/10ps

module pixel_pipe #(
    parameter int H_VISIBLE = 16
)(
    input  wire logic                           clk,
    input  wire logic                           reset_i,
    input  wire logic [$clog2(H_VISIBLE)-1:0]   h_count_i,  // visible part is enough
    input  wire vid_pkg::addr_t                 v_count_i,
    input  wire logic                           de_i,
    input  wire logic                           hsync_i,
    input  wire logic                           vsync_i,
    input  wire logic                           xr_wr_i,
    input  wire vid_pkg::xr_addr_t              xr_addr_i,
    input  wire vid_pkg::word_t                 xr_data_i,
    input  wire vid_pkg::word_t                 vram_data_i,    // cycle after vram_rd_o
    output logic                                vram_rd_o,
    output vid_pkg::addr_t                      vram_addr_o,
    output vid_pkg::rgb_t                       rgb_o,
    output logic                                hsync_o,
    output logic                                vsync_o,
    output logic                                dv_de_o
);

import vid_pkg::*;

localparam int WORDS_PER_LINE = H_VISIBLE / 4;

rgb_t       palette [16];
word_t      pix_word;       // top nibble is the current pixel
cidx_t      pix_idx;
logic       word_due;       // fetched word on vram_data_i now
logic [2:0] de_d;           // delay lines, bit 2 drives the outputs
logic [2:0] hs_d;
logic [2:0] vs_d;

assign vram_rd_o   = de_i && (h_count_i[1:0] == 2'd0);     // first pixel of a group
assign vram_addr_o = addr_t'(v_count_i * WORDS_PER_LINE) + addr_t'(h_count_i >> 2);
assign pix_idx     = pix_word[15:12];
assign dv_de_o     = de_d[2];
assign hsync_o     = hs_d[2];
assign vsync_o     = vs_d[2];

always_ff @(posedge clk) begin
    if (word_due) begin
        pix_word <= vram_data_i;
    end else begin
        pix_word <= {pix_word[11:0], 4'h0};    // next pixel to the top
    end
    if (xr_wr_i && (xr_addr_i & 5'h10) == XR_PALETTE_BASE) begin
        palette[xr_addr_i[3:0]] <= xr_data_i[11:0];
    end
end

always_ff @(posedge clk) begin
    if (reset_i) begin
        word_due <= 1'b0;
        de_d     <= '0;
        hs_d     <= '0;
        vs_d     <= '0;
        rgb_o    <= '0;
    end else begin
        word_due <= vram_rd_o;
        de_d     <= {de_d[1:0], de_i};
        hs_d     <= {hs_d[1:0], hsync_i};
        vs_d     <= {vs_d[1:0], vsync_i};
        rgb_o    <= de_d[1] ? palette[pix_idx] : '0;  // black in blanking
    end
end

// fetches stay four apart, the arbiter uses the gaps for the CPU
assert property (@(posedge clk) disable iff (reset_i)
    vram_rd_o |-> ##1 !vram_rd_o [*3])
    else $error("vram fetch too close to the last one");

endmodule

`default_nettype wire

//--- design/intr_ctrl.sv
/*
 * intr_ctrl
 * raster line compare register, pending interrupt status and the
 * one cycle CPU interrupt strobe
 */
`default_nettype none
`timescale 1ns/10ps

module intr_ctrl(
    input  wire logic               clk,
    input  wire logic               reset_i,
    input  wire logic               line_start_i,
    input  wire logic               vblank_start_i,
    input  wire vid_pkg::word_t     v_count_i,
    input  wire logic               xr_wr_i,
    input  wire vid_pkg::xr_addr_t  xr_addr_i,
    input  wire vid_pkg::word_t     xr_data_i,
    input  wire vid_pkg::intr_t     intr_mask_i,
    input  wire vid_pkg::intr_t     intr_clear_i,   // CPU acknowledge
    output vid_pkg::intr_t          intr_status_o,  // pending sources
    output logic                    bus_intr_o
);

import vid_pkg::*;

word_t  line_cmp;       // XR_LINE_CMP
intr_t  trigger;

always_comb begin
    trigger              = '0;
    trigger[INTR_LINE]   = line_start_i && (v_count_i == line_cmp);
    trigger[INTR_VBLANK] = vblank_start_i;
end

always_ff @(posedge clk) begin
    if (reset_i) begin
        line_cmp      <= '0;
        intr_status_o <= '0;
        bus_intr_o    <= 1'b0;
    end else begin
        if (xr_wr_i && xr_addr_i == XR_LINE_CMP) begin
            line_cmp <= xr_data_i;
        end
        // strobe only for enabled sources not already pending
        bus_intr_o    <= |(trigger & intr_mask_i & ~intr_status_o);
        intr_status_o <= (intr_status_o | trigger) & ~intr_clear_i;    // clear wins
    end
end

endmodule

`default_nettype wire

//--- design/vid_top.sv
/*
 * vid_top
 * raster display controller top level
 * sets the frame timing and connects the bus registers, vram
 * arbiter, timing generator, pixel pipeline and interrupt unit
 */
`default_nettype none
`timescale 1ns/10ps

module vid_top #(
    parameter int H_VISIBLE = 16,
    parameter int H_FRONT   = 2,
    parameter int H_SYNC    = 4,
    parameter int H_BACK    = 2,
    parameter int V_VISIBLE = 8,
    parameter int V_FRONT   = 1,
    parameter int V_SYNC    = 2,
    parameter int V_BACK    = 1
)(
    input  wire logic           clk,
    input  wire logic           reset_i,
    input  wire logic           bus_cs_n_i,
    input  wire logic           bus_rd_nwr_i,
    input  wire logic [3:0]     bus_reg_num_i,
    input  wire logic           bus_bytesel_i,
    input  wire logic [7:0]     bus_data_i,
    output logic      [7:0]     bus_data_o,
    output logic                bus_intr_o,
    output logic      [3:0]     red_o,
    output logic      [3:0]     green_o,
    output logic      [3:0]     blue_o,
    output logic                hsync_o,
    output logic                vsync_o,
    output logic                dv_de_o
);

import vid_pkg::*;

localparam int H_W = $clog2(H_VISIBLE + H_FRONT + H_SYNC + H_BACK);
localparam int V_W = $clog2(V_VISIBLE + V_FRONT + V_SYNC + V_BACK);

logic [H_W-1:0] h_count;
logic [V_W-1:0] v_count;
logic           hsync;
logic           vsync;
logic           de;
logic           line_start;
logic           vblank_start;

logic           vid_rd;             // pixel fetch
addr_t          vid_addr;
word_t          vid_data;
logic           cpu_req;            // bus register vram access
logic           cpu_wr;
logic           cpu_ack;
addr_t          cpu_addr;
word_t          cpu_wdata;
word_t          cpu_rdata;

logic           xr_wr;              // XR write strobe
xr_addr_t       xr_addr;
word_t          xr_data;

intr_t          intr_mask;
intr_t          intr_clear;
intr_t          intr_status;

bus_regs bus_regs(
    .clk(clk),                          .reset_i(reset_i),
    .bus_cs_n_i(bus_cs_n_i),            .bus_rd_nwr_i(bus_rd_nwr_i),
    .bus_reg_num_i(bus_reg_num_i),      .bus_bytesel_i(bus_bytesel_i),
    .bus_data_i(bus_data_i),            .bus_data_o(bus_data_o),
    .vram_ack_i(cpu_ack),               .vram_data_i(cpu_rdata),
    .intr_status_i(intr_status),
    .vram_req_o(cpu_req),               .vram_wr_o(cpu_wr),
    .vram_addr_o(cpu_addr),             .vram_wdata_o(cpu_wdata),
    .xr_wr_o(xr_wr),                    .xr_addr_o(xr_addr),
    .xr_data_o(xr_data),
    .intr_mask_o(intr_mask),            .intr_clear_o(intr_clear)
);

vram_arb vram_arb(
    .clk(clk),                          .reset_i(reset_i),
    .vid_rd_i(vid_rd),                  .vid_addr_i(vid_addr),
    .vid_data_o(vid_data),
    .cpu_req_i(cpu_req),                .cpu_wr_i(cpu_wr),
    .cpu_addr_i(cpu_addr),              .cpu_wdata_i(cpu_wdata),
    .cpu_ack_o(cpu_ack),                .cpu_rdata_o(cpu_rdata)
);

video_timing #(
    .H_VISIBLE(H_VISIBLE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
    .V_VISIBLE(V_VISIBLE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK)
) video_timing(
    .clk(clk),                          .reset_i(reset_i),
    .h_count_o(h_count),                .v_count_o(v_count),
    .hsync_o(hsync),                    .vsync_o(vsync),
    .de_o(de),                          .line_start_o(line_start),
    .frame_start_o(),                   .vblank_start_o(vblank_start)
);

pixel_pipe #(
    .H_VISIBLE(H_VISIBLE)
) pixel_pipe(
    .clk(clk),                          .reset_i(reset_i),
    .h_count_i(h_count[$clog2(H_VISIBLE)-1:0]),
    .v_count_i(addr_t'(v_count)),
    .de_i(de),                          .hsync_i(hsync),
    .vsync_i(vsync),
    .xr_wr_i(xr_wr),                    .xr_addr_i(xr_addr),
    .xr_data_i(xr_data),
    .vram_data_i(vid_data),             .vram_rd_o(vid_rd),
    .vram_addr_o(vid_addr),
    .rgb_o({red_o, green_o, blue_o}),
    .hsync_o(hsync_o),                  .vsync_o(vsync_o),
    .dv_de_o(dv_de_o)
);

intr_ctrl intr_ctrl(
    .clk(clk),                          .reset_i(reset_i),
    .line_start_i(line_start),          .vblank_start_i(vblank_start),
    .v_count_i(word_t'(v_count)),
    .xr_wr_i(xr_wr),                    .xr_addr_i(xr_addr),
    .xr_data_i(xr_data),
    .intr_mask_i(intr_mask),            .intr_clear_i(intr_clear),
    .intr_status_o(intr_status),        .bus_intr_o(bus_intr_o)
);

endmodule

`default_nettype wire

//--- bench/tb_ref.svh
/*
 * tb_ref
 * reference model of the display controller for the testbench
 * vram and palette mirrors, the expected pixel colour and the
 * byte bus access tasks, included inside tb_top
 */
`ifndef TB_REF_SVH
`define TB_REF_SVH

logic [15:0] vram_mirror [256];     // what the CPU wrote
logic [11:0] pal_mirror  [16];
logic [7:0]  wr_ptr_m;              // model of the write address
logic [7:0]  incr_m;

// colour of the k-th enabled pixel of a frame
function automatic logic [11:0] expected_pixel(input int k);
    int          x;
    int          y;
    logic [15:0] w;
    logic [3:0]  idx;
    x   = k % FRAME_W;
    y   = k / FRAME_W;
    w   = vram_mirror[y * (FRAME_W / 4) + x / 4];     // four pixels per word
    idx = w[4 * (3 - x % 4) +: 4];                    // leftmost pixel in top nibble
    return pal_mirror[idx];
endfunction

// one byte access, cs low for a single cycle
task automatic bus_access(input logic rd, input logic [3:0] num, input logic sel,
                          input logic [7:0] data, output logic [7:0] rdata);
    @(posedge clk);
    #DRIVE_DELAY;
    bus_cs_n    = 1'b0;
    bus_rd_nwr  = rd;
    bus_reg_num = num;
    bus_bytesel = sel;
    bus_wdata   = data;
    @(posedge clk);
    #DRIVE_DELAY;
    bus_cs_n = 1'b1;
    rdata    = bus_rdata;           // registered on the edge just passed
    repeat (ACCESS_GAP - 2) @(posedge clk);
endtask

task automatic reg_write(input logic [3:0] num, input logic [15:0] word);
    logic [7:0] unused_byte;
    bus_access(1'b0, num, 1'b0, word[15:8], unused_byte);   // held
    bus_access(1'b0, num, 1'b1, word[7:0], unused_byte);    // commit
endtask

task automatic reg_read(input logic [3:0] num, output logic [15:0] word);
    logic [7:0] hi;
    logic [7:0] lo;
    bus_access(1'b1, num, 1'b0, 8'h00, hi);
    bus_access(1'b1, num, 1'b1, 8'h00, lo);     // low byte steps REG_DATA
    word = {hi, lo};
endtask

task automatic set_write_pos(input logic [15:0] addr, input logic [15:0] incr);
    reg_write(REG_WR_INCR, incr);
    reg_write(REG_WR_ADDR, addr);
    wr_ptr_m = addr[7:0];
    incr_m   = incr[7:0];
endtask

task automatic vram_put(input logic [15:0] word);
    reg_write(REG_DATA, word);
    vram_mirror[wr_ptr_m] = word;
    wr_ptr_m              = wr_ptr_m + incr_m;
endtask

// random colours into all 16 entries
task automatic palette_load();
    int rnd;
    reg_write(REG_XR_ADDR, {11'b0, XR_PALETTE_BASE});
    for (int i = 0; i < 16; i++) begin
        rnd = $random(seed);
        reg_write(REG_XR_DATA, {4'h0, rnd[11:0]});  // XR address steps itself
        pal_mirror[i] = rnd[11:0];
    end
endtask

`endif

//--- bench/tb_top.sv
/*
 * tb_top
 * testbench for the raster display controller
 * vram access through the byte bus, pixel output against the
 * palette rule, sync timing and both interrupt sources
 */
`default_nettype none
`timescale 1ns/10ps

module tb_top;

import vid_pkg::*;

localparam int CLK_PERIOD   = 40;
localparam int DRIVE_DELAY  = 5;        // input skew after the rising edge
localparam int RESET_CYCLES = 16;
localparam int FRAME_W      = 16;       // visible pixels per line
localparam int FRAME_H      = 8;        // visible lines
localparam int TOTAL_W      = 24;       // cycles per line
localparam int TOTAL_H      = 12;       // lines per frame
localparam int FRAME_CYCLES = TOTAL_W * TOTAL_H;
localparam int ACCESS_GAP   = 8;        // cycles from one bus access to the next
// 20 frames of waiting plus 64 words written and read back, four byte accesses each
localparam int TIMEOUT_CYCLES = 20 * FRAME_CYCLES + 64 * 4 * ACCESS_GAP;

logic       clk;
logic       reset;
logic       bus_cs_n;
logic       bus_rd_nwr;
logic [3:0] bus_reg_num;
logic       bus_bytesel;
logic [7:0] bus_wdata;
logic [7:0] bus_rdata;
logic       bus_intr;
logic [3:0] red;
logic [3:0] green;
logic [3:0] blue;
logic       hsync;
logic       vsync;
logic       dv_de;
rgb_t       rgb_seen;

integer     seed;
int         errors      = 0;
int         tests       = 0;
int         cycle_count = 0;

// output monitor state, updated on the falling edge
logic       hs_prev     = 1'b0;
logic       vs_prev     = 1'b0;
logic       intr_prev   = 1'b0;
int         hs_gap      = 0;        // cycles since last hsync rise
int         hs_period   = 0;
int         hs_in_frame = 0;
int         frame_hs    = 0;        // hsync pulses in the last full frame
int         vs_rises    = 0;
int         intr_pulses = 0;
int         intr_cycle  = 0;        // cycle count at the last bus_intr pulse
logic       frame_arm   = 1'b0;     // pixel check requested
logic       frame_run   = 1'b0;     // inside the checked frame
logic       frame_done  = 1'b0;
int         de_seen     = 0;        // enabled pixels so far

assign rgb_seen = {red, green, blue};

`include "tb_ref.svh"

vid_top uut(
    .clk(clk),                      .reset_i(reset),
    .bus_cs_n_i(bus_cs_n),          .bus_rd_nwr_i(bus_rd_nwr),
    .bus_reg_num_i(bus_reg_num),    .bus_bytesel_i(bus_bytesel),
    .bus_data_i(bus_wdata),         .bus_data_o(bus_rdata),
    .bus_intr_o(bus_intr),
    .red_o(red),                    .green_o(green),
    .blue_o(blue),
    .hsync_o(hsync),                .vsync_o(vsync),
    .dv_de_o(dv_de)
);

always #(CLK_PERIOD / 2) clk = ~clk;

task automatic check_value(input logic [31:0] got, input logic [31:0] expected,
                           input string what);
    if (got !== expected) begin
        $display("ERR %0t ns: %s, got %0h expected %0h", $time, what, got, expected);
        errors++;
    end
endtask

task automatic report_test(input string name, input int errs_before);
    tests++;
    if (errors == errs_before)
        $display("test %0d %s: ok", tests, name);
    else
        $display("test %0d %s: %0d errors", tests, name, errors - errs_before);
endtask

// bounded wait for the next bus_intr pulse after count since
task automatic wait_intr_pulse(input int since, input string what);
    int waited;
    waited = 0;
    while (intr_pulses == since && waited < 2 * FRAME_CYCLES) begin
        @(posedge clk);
        waited++;
    end
    if (intr_pulses == since) begin
        $display("%s: no interrupt pulse within two frames, at %0t ns", what, $time);
        errors++;
    end
endtask

// output monitor and pixel compare, sampled mid cycle
always @(negedge clk) begin
    if (hsync && !hs_prev) begin
        hs_period = hs_gap;
        hs_gap    = 1;
        hs_in_frame++;
    end else begin
        hs_gap++;
    end
    if (vsync && !vs_prev) begin
        frame_hs    = hs_in_frame;
        hs_in_frame = 0;
        vs_rises++;
    end
    if (bus_intr) begin
        intr_pulses++;
        intr_cycle = cycle_count;
        check_value(32'(intr_prev), 0, "bus_intr_o high for more than one cycle");
    end
    if (frame_arm) begin
        if (!frame_run) begin
            if (!vsync && vs_prev) begin     // last blank line follows, then the frame
                frame_run = 1'b1;
                de_seen   = 0;
            end
        end else if (dv_de) begin
            check_value(32'(rgb_seen), 32'(expected_pixel(de_seen)),
                        $sformatf("colour of pixel %0d", de_seen));
            de_seen++;
            if (de_seen == FRAME_W * FRAME_H) begin
                frame_run  = 1'b0;
                frame_arm  = 1'b0;
                frame_done = 1'b1;
            end
        end else begin
            check_value(32'(rgb_seen), 0, "rgb not black outside display enable");
        end
    end
    hs_prev   = hsync;
    vs_prev   = vsync;
    intr_prev = bus_intr;
end

always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES) begin
        $display("timeout: run still going after %0d cycles", TIMEOUT_CYCLES);
        $display("Test failures found");
        $finish;
    end
end

initial begin
    word_t w;
    int    rnd;
    int    errs_before;
    int    since;
    int    vblank_cycle;
    clk         = 1'b0;
    reset       = 1'b1;
    bus_cs_n    = 1'b1;
    bus_rd_nwr  = 1'b1;
    bus_reg_num = 4'h0;
    bus_bytesel = 1'b0;
    bus_wdata   = 8'h00;
    seed        = 71;
    repeat (RESET_CYCLES) @(posedge clk);
    #DRIVE_DELAY;
    reset = 1'b0;

    // 64 words, step 1
    errs_before = errors;
    set_write_pos(16'h0000, 16'h0001);
    for (int i = 0; i < 64; i++) begin
        rnd = $random(seed);
        vram_put(rnd[15:0]);
    end
    reg_write(REG_RD_ADDR, 16'h0000);       // prefetch of word 0
    for (int i = 0; i < 64; i++) begin
        reg_read(REG_DATA, w);
        check_value(32'(w), 32'(vram_mirror[i]), $sformatf("vram word %0d, incr 1", i));
    end
    report_test("vram write and read back, increment 1", errs_before);

    // step 4, interleaved with the words above
    errs_before = errors;
    set_write_pos(16'h0002, 16'h0004);
    for (int i = 0; i < 16; i++) begin
        rnd = $random(seed);
        vram_put(rnd[15:0]);
    end
    reg_write(REG_RD_ADDR, 16'h0002);       // reads step by the same increment
    for (int i = 0; i < 16; i++) begin
        reg_read(REG_DATA, w);
        check_value(32'(w), 32'(vram_mirror[2 + 4 * i]),
                    $sformatf("vram word %0d, incr 4", 2 + 4 * i));
    end
    report_test("vram write and read back, increment 4", errs_before);

    // palette, then one whole frame of pixels
    errs_before = errors;
    palette_load();
    frame_done = 1'b0;
    frame_arm  = 1'b1;
    while (!frame_done) @(posedge clk);
    report_test("pixel colours over one frame", errs_before);

    errs_before = errors;
    since       = vs_rises;
    while (vs_rises < since + 2) @(posedge clk);   // one full frame between
    check_value(32'(hs_period), TOTAL_W, "cycles between hsync rises");
    check_value(32'(frame_hs), TOTAL_H, "hsync pulses per frame");
    report_test("sync timing", errs_before);

    // vblank source, enabled then masked
    errs_before = errors;
    since       = intr_pulses;
    reg_write(REG_INT_CTRL, 16'h0203);      // mask vblank, clear both
    wait_intr_pulse(since, "vblank interrupt");
    vblank_cycle = intr_cycle;
    reg_read(REG_INT_CTRL, w);
    check_value(32'(w[9:8]), 2, "interrupt mask readback");
    check_value(32'(w[1]), 1, "vblank status after pulse");
    reg_write(REG_INT_CTRL, 16'h0202);      // clear vblank, keep mask
    reg_read(REG_INT_CTRL, w);
    check_value(32'(w[1]), 0, "vblank status after clear");
    reg_write(REG_INT_CTRL, 16'h0003);      // mask off
    since = intr_pulses;
    repeat (FRAME_CYCLES + TOTAL_W) @(posedge clk);
    check_value(32'(intr_pulses), 32'(since), "interrupt pulses with mask at zero");
    reg_read(REG_INT_CTRL, w);
    check_value(32'(w[1]), 1, "vblank status with mask at zero");
    report_test("vblank interrupt", errs_before);

    // line compare on line 3
    errs_before = errors;
    since       = intr_pulses;
    reg_write(REG_XR_ADDR, {11'b0, XR_LINE_CMP});
    reg_write(REG_XR_DATA, 16'h0003);
    reg_write(REG_INT_CTRL, 16'h0103);      // mask line, clear both
    wait_intr_pulse(since, "line interrupt");
    // line 3 starts seven lines after the first blank line
    check_value(32'((intr_cycle - vblank_cycle) % FRAME_CYCLES),
                32'((TOTAL_H - FRAME_H + 3) * TOTAL_W), "line interrupt cycles after vblank");
    reg_read(REG_INT_CTRL, w);
    check_value(32'(w[0]), 1, "line status after pulse");
    report_test("line compare interrupt", errs_before);

    $display("%0d tests run, %0d errors", tests, errors);
    if (errors == 0) begin
        $display("All tests passed!");
    end else begin
        $display("Test failures found");
    end
    $finish;
end

endmodule

`default_nettype wire

//--- list.f
+incdir+bench
design/vid_pkg.sv
design/video_timing.sv
design/vram_arb.sv
design/bus_regs.sv
design/pixel_pipe.sv
design/intr_ctrl.sv
design/vid_top.sv
bench/tb_top.sv

//--- run.sh
#!/bin/sh
# build the testbench with Verilator, run it and look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f list.f --top-module tb_top -o tb_sim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

out=$(./obj_dir/tb_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qF "All tests passed!"; then
    exit 0
fi
exit 1
